//--- tb.f
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_me_reg.sv
rtl/mem_access.sv
rtl/data_mem.sv
rtl/mem_wb_reg.sv
rtl/ex_mem_top.sv
testbench/tb_ex_mem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -sv
TOP       ?= tb_ex_mem
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_ex_mem.sv
`timescale 1ns/10ps

module tb_ex_mem;
    import ex_pkg::*;

    localparam int N_OPS = 16 + 200 + 120 + 60 + 40 + 8;
    localparam int LIMIT = N_OPS + 16 + 50;

    typedef struct packed {
        logic [63:0] pc, rs1, rs2, imm;
        alu_op_e     alu_op;
        logic        op32, use_imm, use_pc;
        wd_sel_e     wd_sel;
        logic        write_rd;
        logic [4:0]  rd;
        logic        mem_read;
        logic [3:0]  load_bytes;
        logic        load_sext, mem_write;
        logic [7:0]  store_mask;
        logic        jal, jalr, branch, bubble, flush;
    } uop_t;

    typedef struct packed {
        int          due;
        logic        we;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        redir;
        logic [63:0] rpc;
    } exp_t;

    logic clk = 1'b0;
    logic reset_i = 1'b1;
    uop_t cur;
    logic wb_we, redirect;
    logic [4:0] wb_rd;
    logic [63:0] wb_data, redirect_pc;
    logic [15:0] lfsr = 16'd28;
    logic [7:0] sh_mem [128];
    exp_t exp_q[$];
    string name_q[$];
    int cyc = 0;
    int mism_cnt = 0;
    int other_cnt = 0;

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    ex_mem_top #(.MEM_WORDS(256)) u_dut (
        .clk(clk), .reset_i(reset_i), .pc_i(cur.pc), .rs1_i(cur.rs1), .rs2_i(cur.rs2),
        .imm_i(cur.imm), .alu_op_i(cur.alu_op), .op32_i(cur.op32), .use_imm_i(cur.use_imm),
        .use_pc_i(cur.use_pc), .wd_sel_i(cur.wd_sel), .write_rd_i(cur.write_rd),
        .rd_i(cur.rd), .mem_read_i(cur.mem_read), .load_bytes_i(cur.load_bytes),
        .load_sext_i(cur.load_sext), .mem_write_i(cur.mem_write),
        .store_mask_i(cur.store_mask), .jal_i(cur.jal), .jalr_i(cur.jalr),
        .branch_i(cur.branch), .bubble_i(cur.bubble), .flush_i(cur.flush),
        .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] next_lfsr(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    function automatic logic [63:0] ref_alu(uop_t u);
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] w;
        a = u.use_pc ? u.pc : u.rs1;
        b = u.use_imm ? u.imm : u.rs2;
        if (u.op32) begin
            case (u.alu_op)
                ALU_SUB: w = a[31:0] - b[31:0];
                ALU_SLL: w = a[31:0] << b[4:0];
                ALU_SRL: w = a[31:0] >> b[4:0];
                ALU_SRA: w = $signed(a[31:0]) >>> b[4:0];
                default: w = a[31:0] + b[31:0];
            endcase
            return {{32{w[31]}}, w};
        end
        case (u.alu_op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[5:0];
            ALU_SRL: return a >> b[5:0];
            ALU_SRA: return $signed(a) >>> b[5:0];
            ALU_SLT, ALU_LT: return 64'($signed(a) < $signed(b));
            ALU_SLTU, ALU_LTU: return 64'(a < b);
            ALU_EQ:  return 64'(a == b);
            ALU_NE:  return 64'(a != b);
            ALU_GE:  return 64'($signed(a) >= $signed(b));
            default: return 64'(a >= b);
        endcase
    endfunction

    // little endian bytes from the shadow memory, then extension
    function automatic logic [63:0] ref_load(logic [6:0] addr, int n, logic sext);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v[8*i +: 8] = sh_mem[addr + 7'(i)];
        for (int i = 8 * n; i < 64; i++) v[i] = sext & v[8*n-1];
        return v;
    endfunction

    function automatic exp_t ref_result(uop_t u);
        exp_t e;
        logic [63:0] r;
        logic live;
        r = ref_alu(u);
        live = !(u.bubble || u.flush);
        e.due = 0;
        e.we = live && u.write_rd && (u.rd != 0);
        e.rd = u.rd;
        case (u.wd_sel)
            WD_MEM:  e.data = ref_load(r[6:0], int'(u.load_bytes), u.load_sext);
            WD_PC4:  e.data = u.pc + 64'd4;
            WD_IMM:  e.data = u.imm;
            default: e.data = r;
        endcase
        e.redir = live && (u.jal || u.jalr || (u.branch && r != 0));
        e.rpc = u.jalr ? (r & ~64'd1) : u.pc + u.imm;
        return e;
    endfunction

    task automatic issue_op(input uop_t u, input string name);
        exp_t e;
        logic [63:0] addr;
        @(posedge clk);
        cur <= u;
        e = ref_result(u);
        e.due = cyc + 3;
        exp_q.push_back(e);
        name_q.push_back(name);
        addr = ref_alu(u);
        if (u.mem_write && !u.bubble && !u.flush) begin
            for (int i = 0; i < 8; i++) begin
                if (u.store_mask[i]) sh_mem[addr[6:0] + 7'(i)] = u.rs2[8*i +: 8];
            end
        end
    endtask

    // memory op at byte address a, through rs1 + imm
    function automatic uop_t mem_op(logic [6:0] a, int n, logic wr);
        uop_t u;
        u = '0;
        u.use_imm = 1'b1;
        u.rs1 = 64'h40;
        u.imm = 64'(a) - 64'h40;
        u.mem_write = wr;
        u.store_mask = 8'((9'd1 << n) - 9'd1);
        u.mem_read = !wr;
        u.load_bytes = 4'(n);
        u.write_rd = !wr;
        u.wd_sel = wr ? WD_ALU : WD_MEM;
        return u;
    endfunction

    always @(negedge clk) begin
        exp_t e;
        string nm;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            nm = name_q.pop_front();
            assert (wb_we === e.we) else begin
                $display("mismatch %s wb_we expected %0b actual %0b", nm, e.we, wb_we);
                mism_cnt++;
            end
            if (e.we) begin
                assert (wb_rd === e.rd && wb_data === e.data) else begin
                    $display("mismatch %s rd/data expected %0d/%h actual %0d/%h",
                             nm, e.rd, e.data, wb_rd, wb_data);
                    mism_cnt++;
                end
            end
            assert (redirect === e.redir) else begin
                $display("mismatch %s redirect expected %0b actual %0b", nm, e.redir, redirect);
                mism_cnt++;
            end
            if (e.redir) begin
                assert (redirect_pc === e.rpc) else begin
                    $display("mismatch %s redirect_pc expected %h actual %h",
                             nm, e.rpc, redirect_pc);
                    mism_cnt++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (cyc >= LIMIT) begin
            $display("timeout after %0d cycles with %0d results outstanding", cyc, exp_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        uop_t u;
        logic [63:0] v;
        logic [63:0] k;
        int n;
        cur = '0;
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        assert (wb_we === 1'b0 && redirect === 1'b0) else begin
            $display("outputs not idle after reset");
            other_cnt++;
        end
        // fill pattern over the whole test region
        for (int w = 0; w < 16; w++) begin
            u = mem_op(7'(8 * w), 8, 1'b1);
            u.rs2 = 64'h0123_4567_89ab_cdef ^ (64'(8 * w) * 64'h9e37_79b9_7f4a_7c15);
            issue_op(u, "fill");
        end
        for (int i = 0; i < 200; i++) begin
            u = '0;
            rand_bits(4, v);
            u.alu_op = alu_op_e'(v[3:0]);
            rand_bits(3, k);
            u.op32 = k[0] && (u.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA});
            u.use_imm = k[1];
            u.use_pc = k[2];
            rand_bits(64, u.rs1);
            rand_bits(64, u.rs2);
            rand_bits(64, u.pc);
            rand_bits(12, v);
            u.imm = {{52{v[11]}}, v[11:0]};
            rand_bits(8, v);
            u.rd = v[4:0];
            u.wd_sel = (v[7:5] == 3'd0) ? WD_IMM : WD_ALU;
            u.write_rd = 1'b1;
            issue_op(u, "alu");
        end
        for (int i = 0; i < 120; i++) begin
            rand_bits(12, v);
            n = 1 << v[1:0];
            u = mem_op(v[8:2] & ~7'(n - 1), n, v[9]);
            u.load_sext = v[10];
            rand_bits(64, u.rs2);
            u.rd = 5'd1 + 5'(v[11]);
            issue_op(u, u.mem_write ? "store" : "load");
        end
        for (int i = 0; i < 60; i++) begin
            u = '0;
            rand_bits(32, v);
            u.pc = {v[29:0], 2'b00};
            rand_bits(13, v);
            u.imm = {{51{v[12]}}, v[12:1], 1'b0};
            rand_bits(10, v);
            u.rs1 = {{62{v[3]}}, v[3:2]};
            u.rs2 = {{62{v[5]}}, v[5:4]};
            if (v[1:0] == 2'd0) begin
                u.jal = 1'b1;
            end else if (v[1:0] == 2'd1) begin
                u.jalr = 1'b1;
                u.use_imm = 1'b1;
                rand_bits(64, u.rs1);
            end else begin
                u.branch = 1'b1;
                u.alu_op = alu_op_e'(4'd10 + 4'(v[9:6] % 6));
            end
            u.write_rd = u.jal | u.jalr;
            u.wd_sel = WD_PC4;
            u.rd = 5'd3;
            issue_op(u, u.branch ? "branch" : "jump");
        end
        // dropped store, then the old doubleword must still be there
        for (int i = 0; i < 20; i++) begin
            rand_bits(6, v);
            u = mem_op({v[3:0], 3'b000}, 8, 1'b1);
            u.bubble = v[4];
            u.flush = !v[4];
            u.write_rd = 1'b1;
            u.rd = 5'd5;
            u.jal = v[5];
            rand_bits(64, u.rs2);
            issue_op(u, "dropped");
            u = mem_op({v[3:0], 3'b000}, 8, 1'b0);
            u.rd = 5'd6;
            issue_op(u, "after_drop");
        end
        for (int i = 0; i < 8; i++) begin
            u = '0;
            rand_bits(64, u.imm);
            u.write_rd = 1'b1;
            u.wd_sel = WD_IMM;
            issue_op(u, "rd_zero");
        end
        @(posedge clk);
        cur <= '0;
        while (exp_q.size() != 0) @(posedge clk);
        $display("errors: mismatches %0d, other %0d", mism_cnt, other_cnt);
        if (mism_cnt == 0 && other_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- rtl/ex_mem_top.sv
`timescale 1ns/10ps

module ex_mem_top #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_i,
    input  logic [ex_pkg::XLEN-1:0]       rs1_i,
    input  logic [ex_pkg::XLEN-1:0]       rs2_i,
    input  logic [ex_pkg::XLEN-1:0]       imm_i,
    input  ex_pkg::alu_op_e               alu_op_i,
    input  logic                          op32_i,
    input  logic                          use_imm_i,
    input  logic                          use_pc_i,
    input  ex_pkg::wd_sel_e               wd_sel_i,
    input  logic                          write_rd_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                          mem_read_i,
    input  logic [ex_pkg::LB_W-1:0]       load_bytes_i,
    input  logic                          load_sext_i,
    input  logic                          mem_write_i,
    input  logic [ex_pkg::XBYTES-1:0]     store_mask_i,
    input  logic                          jal_i,
    input  logic                          jalr_i,
    input  logic                          branch_i,
    input  logic                          bubble_i,
    input  logic                          flush_i,
    output logic                          wb_we_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [ex_pkg::XLEN-1:0]       wb_data_o,
    output logic                          redirect_o,
    output logic [ex_pkg::XLEN-1:0]       redirect_pc_o
);
    import ex_pkg::*;

    logic [XLEN-1:0]       alu_res;
    // EX/MEM stage fields
    logic [XLEN-1:0]       m_alu_res;
    logic [XLEN-1:0]       m_pc;
    logic [XLEN-1:0]       m_imm;
    logic [XLEN-1:0]       m_rs2;
    wd_sel_e               m_wd_sel;
    logic                  m_write_rd;
    logic [REG_ADDR_W-1:0] m_rd;
    logic                  m_mem_read;
    logic [LB_W-1:0]       m_load_bytes;
    logic                  m_load_sext;
    logic                  m_mem_write;
    logic [XBYTES-1:0]     m_store_mask;
    logic                  m_jal;
    logic                  m_jalr;
    logic                  m_branch;
    // memory side
    logic [XLEN-1:0]       mem_addr;
    logic [XLEN-1:0]       mem_wdata;
    logic [XBYTES-1:0]     mem_be;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       load_data;
    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;

    ex_alu u_ex_alu (
        .pc_i      (pc_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .imm_i     (imm_i),
        .alu_op_i  (alu_op_i),
        .op32_i    (op32_i),
        .use_imm_i (use_imm_i),
        .use_pc_i  (use_pc_i),
        .alu_res_o (alu_res)
    );

    ex_me_reg u_ex_me_reg (
        .clk          (clk),
        .reset_i      (reset_i),
        .bubble_i     (bubble_i),
        .flush_i      (flush_i),
        .alu_res_i    (alu_res),
        .pc_i         (pc_i),
        .imm_i        (imm_i),
        .rs2_i        (rs2_i),
        .wd_sel_i     (wd_sel_i),
        .write_rd_i   (write_rd_i),
        .rd_i         (rd_i),
        .mem_read_i   (mem_read_i),
        .load_bytes_i (load_bytes_i),
        .load_sext_i  (load_sext_i),
        .mem_write_i  (mem_write_i),
        .store_mask_i (store_mask_i),
        .jal_i        (jal_i),
        .jalr_i       (jalr_i),
        .branch_i     (branch_i),
        .alu_res_o    (m_alu_res),
        .pc_o         (m_pc),
        .imm_o        (m_imm),
        .rs2_o        (m_rs2),
        .wd_sel_o     (m_wd_sel),
        .write_rd_o   (m_write_rd),
        .rd_o         (m_rd),
        .mem_read_o   (m_mem_read),
        .load_bytes_o (m_load_bytes),
        .load_sext_o  (m_load_sext),
        .mem_write_o  (m_mem_write),
        .store_mask_o (m_store_mask),
        .jal_o        (m_jal),
        .jalr_o       (m_jalr),
        .branch_o     (m_branch)
    );

    mem_access u_mem_access (
        .alu_res_i     (m_alu_res),
        .pc_i          (m_pc),
        .imm_i         (m_imm),
        .rs2_i         (m_rs2),
        .mem_read_i    (m_mem_read),
        .load_bytes_i  (m_load_bytes),
        .load_sext_i   (m_load_sext),
        .mem_write_i   (m_mem_write),
        .store_mask_i  (m_store_mask),
        .jal_i         (m_jal),
        .jalr_i        (m_jalr),
        .branch_i      (m_branch),
        .rd_data_i     (mem_rdata),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata),
        .mem_be_o      (mem_be),
        .load_data_o   (load_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_mem (
        .clk     (clk),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .be_i    (mem_be),
        .rdata_o (mem_rdata)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk           (clk),
        .reset_i       (reset_i),
        .wd_sel_i      (m_wd_sel),
        .write_rd_i    (m_write_rd),
        .rd_i          (m_rd),
        .alu_res_i     (m_alu_res),
        .load_data_i   (load_data),
        .pc_i          (m_pc),
        .imm_i         (m_imm),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

//--- rtl/mem_wb_reg.sv
`timescale 1ns/10ps

module mem_wb_reg (
    input  logic                          clk,
    input  logic                          reset_i,
    input  ex_pkg::wd_sel_e               wd_sel_i,
    input  logic                          write_rd_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [ex_pkg::XLEN-1:0]       alu_res_i,
    input  logic [ex_pkg::XLEN-1:0]       load_data_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_i,
    input  logic [ex_pkg::XLEN-1:0]       imm_i,
    input  logic                          redirect_i,
    input  logic [ex_pkg::XLEN-1:0]       redirect_pc_i,
    output logic                          wb_we_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [ex_pkg::XLEN-1:0]       wb_data_o,
    output logic                          redirect_o,
    output logic [ex_pkg::XLEN-1:0]       redirect_pc_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] wb_data_d;

    // writeback source
    always_comb begin
        case (wd_sel_i)
            WD_MEM:  wb_data_d = load_data_i;
            WD_PC4:  wb_data_d = pc_i + XLEN'(4);
            WD_IMM:  wb_data_d = imm_i;
            default: wb_data_d = alu_res_i;
        endcase
    end

    // x0 is never written
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_we_o    <= 1'b0;
            redirect_o <= 1'b0;
        end else begin
            wb_we_o    <= write_rd_i && (rd_i != '0);
            redirect_o <= redirect_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o       <= rd_i;
        wb_data_o     <= wb_data_d;
        redirect_pc_o <= redirect_pc_i;
    end

endmodule

//--- rtl/data_mem.sv
`timescale 1ns/10ps

module data_mem #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic                      clk,
    input  logic [ex_pkg::XLEN-1:0]   addr_i,
    input  logic [ex_pkg::XLEN-1:0]   wdata_i,
    input  logic [ex_pkg::XBYTES-1:0] be_i,
    output logic [ex_pkg::XLEN-1:0]   rdata_o
);
    import ex_pkg::*;

    localparam int unsigned IDX_W = $clog2(MEM_WORDS);

    mem_word_u       mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [XLEN-1:0]  bit_mask;

    // doubleword index, the low three bits pick the lane
    assign idx = addr_i[IDX_W+2:3];

    always_comb begin
        for (int i = 0; i < XBYTES; i++) begin
            bit_mask[i*8 +: 8] = {8{be_i[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (|be_i) begin
            mem[idx].dword <= (mem[idx].dword & ~bit_mask) | (wdata_i & bit_mask);
        end
    end

    assign rdata_o = mem[idx].dword;

endmodule

//--- rtl/mem_access.sv
`timescale 1ns/10ps

module mem_access (
    input  logic [ex_pkg::XLEN-1:0]   alu_res_i,
    input  logic [ex_pkg::XLEN-1:0]   pc_i,
    input  logic [ex_pkg::XLEN-1:0]   imm_i,
    input  logic [ex_pkg::XLEN-1:0]   rs2_i,
    input  logic                      mem_read_i,
    input  logic [ex_pkg::LB_W-1:0]   load_bytes_i,
    input  logic                      load_sext_i,
    input  logic                      mem_write_i,
    input  logic [ex_pkg::XBYTES-1:0] store_mask_i,
    input  logic                      jal_i,
    input  logic                      jalr_i,
    input  logic                      branch_i,
    input  logic [ex_pkg::XLEN-1:0]   rd_data_i,
    output logic [ex_pkg::XLEN-1:0]   mem_addr_o,
    output logic [ex_pkg::XLEN-1:0]   mem_wdata_o,
    output logic [ex_pkg::XBYTES-1:0] mem_be_o,
    output logic [ex_pkg::XLEN-1:0]   load_data_o,
    output logic                      redirect_o,
    output logic [ex_pkg::XLEN-1:0]   redirect_pc_o
);
    import ex_pkg::*;

    logic [2:0]      lane;
    mem_word_u       st_src;
    mem_word_u       st_word;
    mem_word_u       ld_word;
    mem_word_u       ld_shift;
    logic [XLEN-1:0] ld_ext;

    assign mem_addr_o = alu_res_i;
    assign lane       = alu_res_i[2:0];

    // store data moves up into its byte lanes
    always_comb begin
        st_src.dword  = rs2_i;
        st_word.dword = '0;
        for (int i = 0; i < XBYTES; i++) begin
            if (i >= int'(lane)) begin
                st_word.bytes[i] = st_src.bytes[i - int'(lane)];
            end
        end
    end

    assign mem_wdata_o = st_word.dword;
    assign mem_be_o    = mem_write_i ? (store_mask_i << lane) : '0;

    // load bytes move down to lane 0
    always_comb begin
        ld_word.dword  = rd_data_i;
        ld_shift.dword = '0;
        for (int i = 0; i < XBYTES; i++) begin
            if (i + int'(lane) < XBYTES) begin
                ld_shift.bytes[i] = ld_word.bytes[i + int'(lane)];
            end
        end
    end

    // extend by access size
    always_comb begin
        case (load_bytes_i)
            4'd1: begin
                ld_ext = {{(XLEN-8){load_sext_i & ld_shift.dword[7]}}, ld_shift.dword[7:0]};
            end
            4'd2: begin
                ld_ext = {{(XLEN-16){load_sext_i & ld_shift.dword[15]}}, ld_shift.dword[15:0]};
            end
            4'd4: begin
                ld_ext = {{(XLEN-32){load_sext_i & ld_shift.dword[31]}}, ld_shift.dword[31:0]};
            end
            default: ld_ext = ld_shift.dword;
        endcase
    end

    assign load_data_o = mem_read_i ? ld_ext : '0;

    // branch taken when the compare gave a nonzero result
    assign redirect_o    = jal_i | jalr_i | (branch_i & (alu_res_i != '0));
    assign redirect_pc_o = jalr_i ? {alu_res_i[XLEN-1:1], 1'b0} : pc_i + imm_i;

endmodule

//--- rtl/ex_me_reg.sv
`timescale 1ns/10ps

module ex_me_reg (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          bubble_i,
    input  logic                          flush_i,
    input  logic [ex_pkg::XLEN-1:0]       alu_res_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_i,
    input  logic [ex_pkg::XLEN-1:0]       imm_i,
    input  logic [ex_pkg::XLEN-1:0]       rs2_i,
    input  ex_pkg::wd_sel_e               wd_sel_i,
    input  logic                          write_rd_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                          mem_read_i,
    input  logic [ex_pkg::LB_W-1:0]       load_bytes_i,
    input  logic                          load_sext_i,
    input  logic                          mem_write_i,
    input  logic [ex_pkg::XBYTES-1:0]     store_mask_i,
    input  logic                          jal_i,
    input  logic                          jalr_i,
    input  logic                          branch_i,
    output logic [ex_pkg::XLEN-1:0]       alu_res_o,
    output logic [ex_pkg::XLEN-1:0]       pc_o,
    output logic [ex_pkg::XLEN-1:0]       imm_o,
    output logic [ex_pkg::XLEN-1:0]       rs2_o,
    output ex_pkg::wd_sel_e               wd_sel_o,
    output logic                          write_rd_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                          mem_read_o,
    output logic [ex_pkg::LB_W-1:0]       load_bytes_o,
    output logic                          load_sext_o,
    output logic                          mem_write_o,
    output logic [ex_pkg::XBYTES-1:0]     store_mask_o,
    output logic                          jal_o,
    output logic                          jalr_o,
    output logic                          branch_o
);
    import ex_pkg::*;

    // a bubble slot is all zeros, nothing writes or redirects
    always_ff @(posedge clk) begin
        if (reset_i || bubble_i || flush_i) begin
            alu_res_o    <= '0;
            pc_o         <= '0;
            imm_o        <= '0;
            rs2_o        <= '0;
            wd_sel_o     <= WD_ALU;
            write_rd_o   <= 1'b0;
            rd_o         <= '0;
            mem_read_o   <= 1'b0;
            load_bytes_o <= '0;
            load_sext_o  <= 1'b0;
            mem_write_o  <= 1'b0;
            store_mask_o <= '0;
            jal_o        <= 1'b0;
            jalr_o       <= 1'b0;
            branch_o     <= 1'b0;
        end else begin
            alu_res_o    <= alu_res_i;
            pc_o         <= pc_i;
            imm_o        <= imm_i;
            rs2_o        <= rs2_i;
            wd_sel_o     <= wd_sel_i;
            write_rd_o   <= write_rd_i;
            rd_o         <= rd_i;
            mem_read_o   <= mem_read_i;
            load_bytes_o <= load_bytes_i;
            load_sext_o  <= load_sext_i;
            mem_write_o  <= mem_write_i;
            store_mask_o <= store_mask_i;
            jal_o        <= jal_i;
            jalr_o       <= jalr_i;
            branch_o     <= branch_i;
        end
    end

endmodule

//--- rtl/ex_alu.sv
`timescale 1ns/10ps

module ex_alu (
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [ex_pkg::XLEN-1:0] rs1_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    input  ex_pkg::alu_op_e         alu_op_i,
    input  logic                    op32_i,
    input  logic                    use_imm_i,
    input  logic                    use_pc_i,
    output logic [ex_pkg::XLEN-1:0] alu_res_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] res_d;
    logic [5:0]      shamt_d;
    logic [31:0]     a_w;
    logic [31:0]     b_w;
    logic [4:0]      shamt_w;
    logic [31:0]     res_w;

    // operand select, pc for auipc style ops
    assign op_a = use_pc_i ? pc_i : rs1_i;
    assign op_b = use_imm_i ? imm_i : rs2_i;

    assign shamt_d = op_b[5:0];
    assign a_w     = op_a[31:0];
    assign b_w     = op_b[31:0];
    assign shamt_w = op_b[4:0];

    // full width result
    always_comb begin
        case (alu_op_i)
            ALU_ADD:  res_d = op_a + op_b;
            ALU_SUB:  res_d = op_a - op_b;
            ALU_AND:  res_d = op_a & op_b;
            ALU_OR:   res_d = op_a | op_b;
            ALU_XOR:  res_d = op_a ^ op_b;
            ALU_SLL:  res_d = op_a << shamt_d;
            ALU_SRL:  res_d = op_a >> shamt_d;
            ALU_SRA:  res_d = $signed(op_a) >>> shamt_d;
            ALU_SLT:  res_d = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: res_d = XLEN'(op_a < op_b);
            ALU_EQ:   res_d = XLEN'(op_a == op_b);
            ALU_NE:   res_d = XLEN'(op_a != op_b);
            ALU_LT:   res_d = XLEN'($signed(op_a) < $signed(op_b));
            ALU_GE:   res_d = XLEN'($signed(op_a) >= $signed(op_b));
            ALU_LTU:  res_d = XLEN'(op_a < op_b);
            ALU_GEU:  res_d = XLEN'(op_a >= op_b);
            default:  res_d = '0;
        endcase
    end

    // word ops, shifts only see 5 bits of shift amount
    always_comb begin
        case (alu_op_i)
            ALU_ADD: res_w = a_w + b_w;
            ALU_SUB: res_w = a_w - b_w;
            ALU_SLL: res_w = a_w << shamt_w;
            ALU_SRL: res_w = a_w >> shamt_w;
            ALU_SRA: res_w = $signed(a_w) >>> shamt_w;
            // the rest only depend on the low half of the full result
            default: res_w = res_d[31:0];
        endcase
    end

    assign alu_res_o = op32_i ? {{(XLEN-32){res_w[31]}}, res_w} : res_d;

endmodule

//--- rtl/ex_pkg.sv
package ex_pkg;

    // data and address width of the RV64 datapath
    localparam int unsigned XLEN = 64;

    // register index width
    localparam int unsigned REG_ADDR_W = 5;

    // bytes per doubleword and width of the load byte count
    localparam int unsigned XBYTES = XLEN / 8;
    localparam int unsigned LB_W = 4;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        // branch compares, result is 1 or 0
        ALU_EQ   = 4'd10,
        ALU_NE   = 4'd11,
        ALU_LT   = 4'd12,
        ALU_GE   = 4'd13,
        ALU_LTU  = 4'd14,
        ALU_GEU  = 4'd15
    } alu_op_e;

    // writeback source
    typedef enum logic [2:0] {
        WD_ALU = 3'd0,
        WD_MEM = 3'd1,
        WD_PC4 = 3'd2,
        WD_IMM = 3'd3
    } wd_sel_e;

    // one RAM word, seen whole or lane by lane
    typedef union packed {
        logic [XLEN-1:0]           dword;
        logic [XBYTES-1:0][7:0]    bytes;
    } mem_word_u;

endpackage
